// ==== source/mips_isa_pkg.sv ====
// mips32 encodings for the jump decoder only; delay slot assumed fixed, no other fields decoded
package mips_isa_pkg;

    // datapath widths
    localparam int INSTR_W = 32;
    localparam int ADDR_W  = 32;

    typedef logic [INSTR_W-1:0] instr_t;  // raw instruction word
    typedef logic [ADDR_W-1:0]  addr_t;   // byte address

    // instruction fields
    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [4:0] reg_idx_t;

    localparam int OPCODE_LSB = 26;  // bits 31:26
    localparam int FUNCT_LSB  = 0;   // bits 5:0, R-type only
    localparam int RD_LSB     = 11;  // bits 15:11

    localparam reg_idx_t REG_ZERO = 5'd0;  // $zero, a write here is discarded

    // opcodes
    localparam opcode_t OP_SPECIAL = 6'd0;  // R-type, look at funct
    localparam opcode_t OP_JAL     = 6'd3;

    // funct codes under SPECIAL
    localparam funct_t FUNCT_JR   = 6'd8;
    localparam funct_t FUNCT_JALR = 6'd9;

    // jump classes seen by the return stack
    typedef logic [1:0] jump_class_t;

    localparam jump_class_t JCLASS_OTHER  = 2'd0;  // never touches the stack
    localparam jump_class_t JCLASS_CALL   = 2'd1;  // push
    localparam jump_class_t JCLASS_RETURN = 2'd2;  // pop, or predict at fetch

endpackage

// ==== source/ras_pkg.sv ====
// return stack sizing; pointer wraps by its own width, so the depth must stay a power of two
package ras_pkg;

    // stack geometry
    localparam int RAS_DEPTH = 32;
    localparam int RAS_PTR_W = 5;  // log2 of the depth

    typedef logic [RAS_PTR_W-1:0] ras_ptr_t;  // slot index

    // occupancy needs one extra bit to hold the full depth
    localparam int RAS_CNT_W = 6;

    // return address is the call plus the delay slot
    localparam logic [31:0] RET_OFFSET = 32'd8;

endpackage

// ==== source/jump_decoder.sv ====
// combinational; only JAL, JALR and JR are recognized, plain J and branches read as other
`timescale 1ns/10ps

module jump_decoder (
    input  mips_isa_pkg::instr_t      instr,
    output mips_isa_pkg::jump_class_t jclass
);
    import mips_isa_pkg::*;

    opcode_t  opcode;
    funct_t   funct;
    reg_idx_t rd;

    // field extraction
    assign opcode = instr[OPCODE_LSB +: $bits(opcode_t)];
    assign funct  = instr[FUNCT_LSB +: $bits(funct_t)];
    assign rd     = instr[RD_LSB +: $bits(reg_idx_t)];

    always_comb begin
        jclass = JCLASS_OTHER;  // default, no stack action
        if (opcode == OP_JAL) begin
            jclass = JCLASS_CALL;  // links into $ra
        end else if (opcode == OP_SPECIAL) begin
            case (funct)
                FUNCT_JALR: begin
                    // jalr with rd = 0 links nowhere, so no return expected
                    if (rd != REG_ZERO) begin
                        jclass = JCLASS_CALL;
                    end
                end
                FUNCT_JR: begin
                    jclass = JCLASS_RETURN;
                end
                default: begin
                    jclass = JCLASS_OTHER;
                end
            endcase
        end
    end

endmodule

// ==== source/return_stack.sv ====
// push and pop must not be high together; full stack drops oldest entry, top_addr undefined when empty
`timescale 1ns/10ps

module return_stack (
    input  logic                CLK,
    input  logic                RESET,
    input  logic                push,
    input  logic                pop,
    input  mips_isa_pkg::addr_t push_addr,
    output mips_isa_pkg::addr_t top_addr,
    output logic                empty
);
    import ras_pkg::*;

    logic [$bits(push_addr)-1:0] entries [RAS_DEPTH];  // circular storage

    ras_ptr_t             wr_ptr;   // next free slot
    ras_ptr_t             nxt_ptr;
    ras_ptr_t             top_idx;
    logic [RAS_CNT_W-1:0] count;    // live entries, saturates at depth
    logic [RAS_CNT_W-1:0] nxt_cnt;
    logic                 full;
    logic                 do_pop;

    assign full   = (count == RAS_CNT_W'(RAS_DEPTH));
    assign do_pop = pop && (count != '0);  // pop on empty is dropped

    // next pointer and count, also used for the bypassed outputs
    always_comb begin
        nxt_ptr = wr_ptr;
        nxt_cnt = count;
        if (push) begin
            nxt_ptr = wr_ptr + 1'b1;  // wraps at the depth
            if (!full) begin
                nxt_cnt = count + 1'b1;
            end
            // when full the write lands on the oldest slot
        end else if (do_pop) begin
            nxt_ptr = wr_ptr - 1'b1;
            nxt_cnt = count - 1'b1;
        end
    end

    // top after this cycle's update
    // a push shows its own address, since the write is not in the array yet
    assign top_idx  = nxt_ptr - 1'b1;
    assign top_addr = push ? push_addr : entries[top_idx];
    assign empty    = (nxt_cnt == '0);

    always_ff @(posedge CLK) begin
        if (push) begin
            entries[wr_ptr] <= push_addr;
        end
    end

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= nxt_ptr;
            count  <= nxt_cnt;
        end
    end

endmodule

// ==== source/ras_predictor.sv ====
// advisory prediction, 1 cycle after fetch; no recovery on mispredict, flush clears only the output
`timescale 1ns/10ps

module ras_predictor (
    input  logic                 CLK,
    input  logic                 RESET,
    input  logic                 flush,
    input  mips_isa_pkg::instr_t fetch_instr,
    input  logic                 commit_valid,
    input  mips_isa_pkg::instr_t commit_instr,
    input  mips_isa_pkg::addr_t  commit_pc,
    output logic                 pred_valid,
    output mips_isa_pkg::addr_t  pred_target
);
    import mips_isa_pkg::*;
    import ras_pkg::*;

    jump_class_t commit_class;
    jump_class_t fetch_class;
    logic        push;
    logic        pop;
    addr_t       push_addr;
    addr_t       stack_top;
    logic        stack_empty;
    logic        fetch_is_ret;

    // retiring side updates the stack
    jump_decoder i_commit_dec (
        .instr  (commit_instr),
        .jclass (commit_class)
    );

    assign push      = commit_valid && (commit_class == JCLASS_CALL);
    assign pop       = commit_valid && (commit_class == JCLASS_RETURN);
    assign push_addr = commit_pc + RET_OFFSET;  // skip the delay slot

    return_stack i_stack (
        .CLK       (CLK),
        .RESET     (RESET),
        .push      (push),
        .pop       (pop),
        .push_addr (push_addr),
        .top_addr  (stack_top),
        .empty     (stack_empty)
    );

    // fetch side only peeks
    jump_decoder i_fetch_dec (
        .instr  (fetch_instr),
        .jclass (fetch_class)
    );

    assign fetch_is_ret = (fetch_class == JCLASS_RETURN);

    always_ff @(posedge CLK or negedge RESET) begin
        if (!RESET) begin
            pred_valid  <= 1'b0;
            pred_target <= '0;
        end else if (flush) begin
            pred_valid  <= 1'b0;  // stack left intact
            pred_target <= '0;
        end else if (fetch_is_ret && !stack_empty) begin
            pred_valid  <= 1'b1;
            pred_target <= stack_top;  // bypassed top
        end else begin
            pred_valid  <= 1'b0;
            pred_target <= '0;
        end
    end

endmodule

// ==== tests/ras_asserts.sv ====
// bound into ras_predictor; watches only the registered outputs, stack contents are not observed
`timescale 1ns/10ps

module ras_asserts (
    input logic                 CLK,
    input logic                 RESET,
    input logic                 flush,
    input mips_isa_pkg::instr_t fetch_instr,
    input logic                 pred_valid,
    input mips_isa_pkg::addr_t  pred_target
);
    import mips_isa_pkg::*;

    logic fetch_jr;
    int   fail_count = 0;  // read by the testbench at the end

    // JR at fetch, decoded here apart from the DUT decoder
    assign fetch_jr = (fetch_instr[31:26] == OP_SPECIAL) && (fetch_instr[5:0] == FUNCT_JR);

    a_flush_clears: assert property (@(posedge CLK) disable iff (!RESET)
        flush |=> !pred_valid)
        else begin
            $error("pred_valid high in the cycle after flush");
            fail_count++;
        end

    a_only_on_return: assert property (@(posedge CLK) disable iff (!RESET)
        !fetch_jr |=> !pred_valid)
        else begin
            $error("pred_valid high after a fetch that is not JR");
            fail_count++;
        end

    // idle target stays at zero
    a_target_zero: assert property (@(posedge CLK) disable iff (!RESET)
        !pred_valid |-> (pred_target == '0))
        else begin
            $error("pred_target not zero while pred_valid is low");
            fail_count++;
        end

endmodule

bind ras_predictor ras_asserts i_asserts (
    .CLK         (CLK),
    .RESET       (RESET),
    .flush       (flush),
    .fetch_instr (fetch_instr),
    .pred_valid  (pred_valid),
    .pred_target (pred_target)
);

// ==== tests/tb_ras_predictor.sv ====
// run from the project root since the trace path is relative to it; expectations come from the trace
`timescale 1ns/10ps

module tb_ras_predictor;
    import mips_isa_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int FIELDS     = 8;    // words per trace line
    localparam int MAX_LINES  = 256;
    localparam int IDX_W      = 11;   // covers FIELDS * MAX_LINES words
    localparam int NUM_TESTS  = 5;

    logic   CLK;
    logic   RESET;
    logic   flush;
    instr_t fetch_instr;
    logic   commit_valid;
    instr_t commit_instr;
    addr_t  commit_pc;
    logic   pred_valid;
    addr_t  pred_target;

    logic [31:0] trace [FIELDS*MAX_LINES];
    int          num_lines    = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          test_errs    = 0;
    int          check_count  = 0;
    int          assert_fails = 0;

    ras_predictor i_dut (
        .CLK          (CLK),
        .RESET        (RESET),
        .flush        (flush),
        .fetch_instr  (fetch_instr),
        .commit_valid (commit_valid),
        .commit_instr (commit_instr),
        .commit_pc    (commit_pc),
        .pred_valid   (pred_valid),
        .pred_target  (pred_target)
    );

    initial CLK = 1'b0;
    always #(CLK_PERIOD/2) CLK = ~CLK;

    function automatic logic [31:0] field(input int line, input int col);
        return trace[IDX_W'(line * FIELDS + col)];
    endfunction

    function automatic string name_of(input int num);
        case (num)
            0: return "reset_empty";
            1: return "call_return";
            2: return "nesting";
            3: return "overflow";
            4: return "flush_commit_valid";
            default: return "unknown";
        endcase
    endfunction

    task automatic drive_line(input int line);
        if (line < num_lines) begin
            flush        = (field(line, 1) != 0);
            fetch_instr  = field(line, 2);
            commit_valid = (field(line, 3) != 0);
            commit_instr = field(line, 4);
            commit_pc    = field(line, 5);
        end else begin
            flush        = 1'b0;  // idle after the last line
            fetch_instr  = '0;
            commit_valid = 1'b0;
            commit_instr = '0;
            commit_pc    = '0;
        end
    endtask

    task automatic check_line(input int line);
        logic  exp_valid;
        addr_t exp_target;
        string name;
        exp_valid  = (field(line, 6) != 0);
        exp_target = field(line, 7);
        name       = name_of(int'(field(line, 0)));
        check_count++;
        if (pred_valid !== exp_valid) begin
            $display("ERR %s line %0d pred_valid expected %0b actual %0b",
                     name, line, exp_valid, pred_valid);
            test_errs++;
        end
        if (pred_target !== exp_target) begin
            $display("ERR %s line %0d pred_target expected %h actual %h",
                     name, line, exp_target, pred_target);
            test_errs++;
        end
    endtask

    task automatic finish_test(input int num);
        if (test_errs == 0) begin
            $display("test %s passed", name_of(num));
            tests_passed++;
        end else begin
            $display("test %s failed with %0d errors", name_of(num), test_errs);
            tests_failed++;
        end
        test_errs = 0;
    endtask

    task automatic run_trace();
        int cur_test;
        cur_test = int'(field(0, 0));
        // outputs still hold their reset values here
        check_count++;
        if (pred_valid !== 1'b0) begin
            $display("ERR %s after reset pred_valid expected 0 actual %0b",
                     name_of(cur_test), pred_valid);
            test_errs++;
        end
        if (pred_target !== '0) begin
            $display("ERR %s after reset pred_target expected 00000000 actual %h",
                     name_of(cur_test), pred_target);
            test_errs++;
        end
        drive_line(0);
        for (int line = 0; line < num_lines; line++) begin
            @(posedge CLK);           // line sampled here
            #2;
            drive_line(line + 1);
            #(CLK_PERIOD - 3);        // just before the next edge
            if (int'(field(line, 0)) != cur_test) begin
                finish_test(cur_test);
                cur_test = int'(field(line, 0));
            end
            check_line(line);
        end
        finish_test(cur_test);
    endtask

    initial begin
        RESET        = 1'b0;
        flush        = 1'b0;
        fetch_instr  = '0;
        commit_valid = 1'b0;
        commit_instr = '0;
        commit_pc    = '0;
        // prefill is never a valid test number, so it marks the end
        for (int i = 0; i < FIELDS*MAX_LINES; i++) begin
            trace[IDX_W'(i)] = 32'hff00_0000 | 32'(i);
        end
        $readmemh("tests/ras_trace.txt", trace);
        while (num_lines < MAX_LINES && field(num_lines, 0) < NUM_TESTS) begin
            num_lines++;
        end
        repeat (3) @(posedge CLK);
        #2;
        RESET = 1'b1;
        if (num_lines == 0) begin
            $display("trace file held no lines, nothing was run");
            tests_failed++;
        end else begin
            run_trace();
        end
        assert_fails = i_dut.i_asserts.fail_count;
        $display("tests passed %0d, failed %0d, checks %0d, assertion failures %0d",
                 tests_passed, tests_failed, check_count, assert_fails);
        if (tests_failed == 0 && assert_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // watchdog, sized from the trace length
    initial begin
        wait (num_lines > 0);
        #((num_lines + 10) * CLK_PERIOD);
        $display("run timed out before the trace finished");
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== src.f ====
source/mips_isa_pkg.sv
source/ras_pkg.sv
source/jump_decoder.sv
source/return_stack.sv
source/ras_predictor.sv
tests/ras_asserts.sv
tests/tb_ras_predictor.sv

// ==== Makefile ====
# Verilator flow for the return address predictor testbench

VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_ras_predictor
FILELIST   = src.f
BUILD_DIR  = obj_dir
PASS_MSG   = ** PASS **

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/ras_trace.txt ====
// test flush fetch_instr commit_valid commit_instr commit_pc exp_pred_valid exp_pred_target
// expected columns are the prediction one cycle after the row; fillers from $random seed 22666144
// reset_empty
0 0 00000000 0 00000000 00000000 0 00000000
0 0 03e00008 0 00000000 00000000 0 00000000
0 0 03e00008 1 03e00008 00400100 0 00000000
0 0 2484a3c1 1 8d6e51f0 00400104 0 00000000
// call_return
1 0 00000000 1 0c100040 00400000 0 00000000
1 0 03e00008 0 00000000 00000000 1 00400008
1 0 00000000 1 03200009 00400020 0 00000000
1 0 03e00008 0 01b7c025 00000000 1 00400008
1 0 08100010 0 00000000 00000000 0 00000000
1 0 00000000 1 03e00008 00400100 0 00000000
1 0 03e00008 0 00000000 00000000 0 00000000
1 0 00000000 1 0320f809 00400200 0 00000000
1 0 03e00008 1 03e00008 00400300 0 00000000
// nesting
2 0 00000000 1 0c100100 00401000 0 00000000
2 0 00000000 1 0c100200 00402000 0 00000000
2 0 03e00008 1 0c100300 00403000 1 00403008
2 0 03e00008 0 00000000 00000000 1 00403008
2 0 03e00008 1 03e00008 00403100 1 00402008
2 0 03e00008 0 00000000 00000000 1 00402008
2 0 00000000 1 03e00008 00402100 0 00000000
2 0 03e00008 0 00000000 00000000 1 00401008
2 0 03e00008 1 03e00008 00401100 0 00000000
// overflow, 34 calls then 32 pop and peek rows
3 0 00000000 1 0c104000 00410010 0 00000000
3 0 00000000 1 0c104000 00410020 0 00000000
3 0 00000000 1 0c104000 00410030 0 00000000
3 0 00000000 1 0c104000 00410040 0 00000000
3 0 00000000 1 0c104000 00410050 0 00000000
3 0 00000000 1 0c104000 00410060 0 00000000
3 0 00000000 1 0c104000 00410070 0 00000000
3 0 00000000 1 0c104000 00410080 0 00000000
3 0 00000000 1 0c104000 00410090 0 00000000
3 0 00000000 1 0c104000 004100a0 0 00000000
3 0 00000000 1 0c104000 004100b0 0 00000000
3 0 00000000 1 0c104000 004100c0 0 00000000
3 0 00000000 1 0c104000 004100d0 0 00000000
3 0 00000000 1 0c104000 004100e0 0 00000000
3 0 00000000 1 0c104000 004100f0 0 00000000
3 0 00000000 1 0c104000 00410100 0 00000000
3 0 00000000 1 0c104000 00410110 0 00000000
3 0 00000000 1 0c104000 00410120 0 00000000
3 0 00000000 1 0c104000 00410130 0 00000000
3 0 00000000 1 0c104000 00410140 0 00000000
3 0 00000000 1 0c104000 00410150 0 00000000
3 0 00000000 1 0c104000 00410160 0 00000000
3 0 00000000 1 0c104000 00410170 0 00000000
3 0 00000000 1 0c104000 00410180 0 00000000
3 0 00000000 1 0c104000 00410190 0 00000000
3 0 00000000 1 0c104000 004101a0 0 00000000
3 0 00000000 1 0c104000 004101b0 0 00000000
3 0 00000000 1 0c104000 004101c0 0 00000000
3 0 00000000 1 0c104000 004101d0 0 00000000
3 0 00000000 1 0c104000 004101e0 0 00000000
3 0 00000000 1 0c104000 004101f0 0 00000000
3 0 00000000 1 0c104000 00410200 0 00000000
3 0 00000000 1 0c104000 00410210 0 00000000
3 0 03e00008 1 0c104000 00410220 1 00410228
3 0 03e00008 1 03e00008 00480000 1 00410218
3 0 03e00008 1 03e00008 00480000 1 00410208
3 0 03e00008 1 03e00008 00480000 1 004101f8
3 0 03e00008 1 03e00008 00480000 1 004101e8
3 0 03e00008 1 03e00008 00480000 1 004101d8
3 0 03e00008 1 03e00008 00480000 1 004101c8
3 0 03e00008 1 03e00008 00480000 1 004101b8
3 0 03e00008 1 03e00008 00480000 1 004101a8
3 0 03e00008 1 03e00008 00480000 1 00410198
3 0 03e00008 1 03e00008 00480000 1 00410188
3 0 03e00008 1 03e00008 00480000 1 00410178
3 0 03e00008 1 03e00008 00480000 1 00410168
3 0 03e00008 1 03e00008 00480000 1 00410158
3 0 03e00008 1 03e00008 00480000 1 00410148
3 0 03e00008 1 03e00008 00480000 1 00410138
3 0 03e00008 1 03e00008 00480000 1 00410128
3 0 03e00008 1 03e00008 00480000 1 00410118
3 0 03e00008 1 03e00008 00480000 1 00410108
3 0 03e00008 1 03e00008 00480000 1 004100f8
3 0 03e00008 1 03e00008 00480000 1 004100e8
3 0 03e00008 1 03e00008 00480000 1 004100d8
3 0 03e00008 1 03e00008 00480000 1 004100c8
3 0 03e00008 1 03e00008 00480000 1 004100b8
3 0 03e00008 1 03e00008 00480000 1 004100a8
3 0 03e00008 1 03e00008 00480000 1 00410098
3 0 03e00008 1 03e00008 00480000 1 00410088
3 0 03e00008 1 03e00008 00480000 1 00410078
3 0 03e00008 1 03e00008 00480000 1 00410068
3 0 03e00008 1 03e00008 00480000 1 00410058
3 0 03e00008 1 03e00008 00480000 1 00410048
3 0 03e00008 1 03e00008 00480000 1 00410038
3 0 03e00008 1 03e00008 00480000 0 00000000
3 0 03e00008 0 00000000 00000000 0 00000000
// flush_commit_valid
4 0 00000000 1 0c100500 00405000 0 00000000
4 1 03e00008 0 00000000 00000000 0 00000000
4 0 03e00008 0 00000000 00000000 1 00405008
4 0 03e00008 0 0c100600 00406000 1 00405008
4 0 03e00008 0 03e00008 00406100 1 00405008
4 1 03e00008 1 03e00008 00406200 0 00000000
4 0 03e00008 0 00000000 00000000 0 00000000
